// File: hdl/coll_pkg.sv
package coll_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Sizes
	////////////////////////////////////////////////////////////////////////////

	localparam int NUM_LINKS = 3;
	localparam int NUM_CTX   = 4;
	localparam int CTX_W     = 2;
	localparam int RANK_W    = 9;
	localparam int DATA_W    = 32;
	localparam int LINK_W    = $clog2(NUM_LINKS);

	// Body is one data word wide, config view padded up to it
	localparam int BODY_W    = DATA_W;
	localparam int CFG_PAD_W = BODY_W - 1 - NUM_LINKS - 2 * RANK_W;

	typedef logic [LINK_W-1:0] link_idx_t;

	typedef enum logic {
		OP_SUM = 1'b0,
		OP_MAX = 1'b1
	} op_e;

	typedef enum logic {
		KIND_CFG  = 1'b0,
		KIND_DATA = 1'b1
	} flit_kind_e;

	////////////////////////////////////////////////////////////////////////////
	// Flit layout
	////////////////////////////////////////////////////////////////////////////

	// Communicator setup, same rank fields as the newcomm word
	typedef struct packed {
		logic [CFG_PAD_W-1:0] pad;
		op_e                  op;
		logic [NUM_LINKS-1:0] child_mask;
		logic [RANK_W-1:0]    root_rank;
		logic [RANK_W-1:0]    local_rank;
	} comm_cfg_t;

	// One child's contribution fills the whole body
	typedef struct packed {
		logic [DATA_W-1:0] value;
	} coll_data_t;

	typedef union packed {
		comm_cfg_t  cfg;
		coll_data_t data;
	} flit_body_u;

	typedef struct packed {
		flit_kind_e        kind;
		logic [CTX_W-1:0]  ctx;
		logic [RANK_W-1:0] src_rank;
		flit_body_u        body;
	} flit_t;

	////////////////////////////////////////////////////////////////////////////
	// Context store and result
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic                 configured;
		op_e                  op;
		logic [NUM_LINKS-1:0] child_mask;
		logic [RANK_W-1:0]    root_rank;
		logic [RANK_W-1:0]    local_rank;
		logic [NUM_LINKS-1:0] rcvd_mask;
		logic [DATA_W-1:0]    acc;
	} ctx_entry_t;

	typedef struct packed {
		logic [CTX_W-1:0]  ctx;
		logic [RANK_W-1:0] root_rank;
		logic [RANK_W-1:0] src_rank;
		logic [DATA_W-1:0] value;
	} result_t;

endpackage

// File: hdl/link_ingress.sv
`timescale 1ns/1ps

module link_ingress (
	input  logic            clk,
	input  logic            rst,
	input  logic            in_valid,
	input  coll_pkg::flit_t in_flit,
	input  logic            gnt,
	output logic            req,
	output logic            busy,
	output coll_pkg::flit_t flit
);

	logic full;

	// Single slot, link holds off while it is occupied
	assign busy = full;
	assign req = full;

	always_ff @(posedge clk) begin
		if (rst) begin
			full <= 1'b0;
		end else if (in_valid) begin
			full <= 1'b1;
		end else if (gnt) begin
			// Store takes the flit at this edge
			full <= 1'b0;
		end
	end

	// Payload only, no reset
	always_ff @(posedge clk) begin
		if (in_valid && !full) begin
			flit <= in_flit;
		end
	end

endmodule

// File: hdl/table_arbiter.sv
`timescale 1ns/1ps

module table_arbiter (
	input  logic                           clk,
	input  logic                           rst,
	input  logic [coll_pkg::NUM_LINKS-1:0] req,
	input  coll_pkg::flit_t                flit [coll_pkg::NUM_LINKS],
	output logic [coll_pkg::NUM_LINKS-1:0] gnt,
	output logic                           sel_valid,
	output coll_pkg::link_idx_t            sel_link,
	output coll_pkg::flit_t                sel_flit
);

	import coll_pkg::*;

	// Last link served
	link_idx_t last;

	////////////////////////////////////////////////////////////////////////////
	// Winner search
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		int cand;

		gnt = '0;
		sel_valid = 1'b0;
		sel_link = '0;
		// Start one past the last winner and wrap around
		for (int k = 1; k <= NUM_LINKS; k++) begin
			cand = (int'(last) + k) % NUM_LINKS;
			if (!sel_valid && req[cand]) begin
				sel_valid = 1'b1;
				sel_link = link_idx_t'(cand);
				gnt[cand] = 1'b1;
			end
		end
	end

	assign sel_flit = flit[sel_link];

	// Reset value makes link 0 first in line
	always_ff @(posedge clk) begin
		if (rst) begin
			last <= link_idx_t'(NUM_LINKS - 1);
		end else if (sel_valid) begin
			last <= sel_link;
		end
	end

endmodule

// File: hdl/context_store.sv
`timescale 1ns/1ps

module context_store (
	input  logic                clk,
	input  logic                rst,
	input  logic                sel_valid,
	input  coll_pkg::link_idx_t sel_link,
	input  coll_pkg::flit_t     sel_flit,
	output logic                result_valid,
	output coll_pkg::result_t   result,
	output logic                drop_valid
);

	import coll_pkg::*;

	ctx_entry_t ctx_tab [NUM_CTX];

	ctx_entry_t           cur;
	ctx_entry_t           nxt;
	comm_cfg_t            cfg;
	coll_data_t           dat;
	logic [NUM_LINKS-1:0] link_bit;
	logic [NUM_LINKS-1:0] rcvd_next;
	logic [DATA_W-1:0]    acc_next;
	logic                 wr_en;
	logic                 done;
	logic                 drop;

	// Same body word, two readings
	assign cfg = sel_flit.body.cfg;
	assign dat = sel_flit.body.data;

	assign cur = ctx_tab[sel_flit.ctx];

	always_comb begin
		link_bit = '0;
		link_bit[sel_link] = 1'b1;
	end

	assign rcvd_next = cur.rcvd_mask | link_bit;

	////////////////////////////////////////////////////////////////////////////
	// Reduction operator
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		if (cur.rcvd_mask == '0) begin
			// First child of this round
			acc_next = dat.value;
		end else if (cur.op == OP_SUM) begin
			acc_next = cur.acc + dat.value;
		end else if (dat.value > cur.acc) begin
			acc_next = dat.value;
		end else begin
			acc_next = cur.acc;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Entry update
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		nxt = cur;
		wr_en = 1'b0;
		done = 1'b0;
		drop = 1'b0;
		if (sel_valid) begin
			if (sel_flit.kind == KIND_CFG) begin
				wr_en = 1'b1;
				nxt.configured = 1'b1;
				nxt.op = cfg.op;
				nxt.child_mask = cfg.child_mask;
				nxt.root_rank = cfg.root_rank;
				nxt.local_rank = cfg.local_rank;
				nxt.rcvd_mask = '0;
				nxt.acc = '0;
			end else if (!cur.configured || (cur.child_mask & link_bit) == '0 ||
				(cur.rcvd_mask & link_bit) != '0) begin
				// Unknown context, link outside the tree, or a repeat
				drop = 1'b1;
			end else if (rcvd_next == cur.child_mask) begin
				// Last child in, rearm for the next round
				wr_en = 1'b1;
				done = 1'b1;
				nxt.rcvd_mask = '0;
				nxt.acc = '0;
			end else begin
				wr_en = 1'b1;
				nxt.rcvd_mask = rcvd_next;
				nxt.acc = acc_next;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_CTX; i++) begin
				ctx_tab[i].configured <= 1'b0;
				ctx_tab[i].rcvd_mask <= '0;
			end
		end else if (wr_en) begin
			ctx_tab[sel_flit.ctx] <= nxt;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Outputs toward the root
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			result_valid <= 1'b0;
			drop_valid <= 1'b0;
		end else begin
			result_valid <= done;
			drop_valid <= drop;
		end
	end

	always_ff @(posedge clk) begin
		if (done) begin
			result.ctx <= sel_flit.ctx;
			result.root_rank <= cur.root_rank;
			result.src_rank <= cur.local_rank;
			result.value <= acc_next;
		end
	end

endmodule

// File: hdl/coll_node.sv
`timescale 1ns/1ps

module coll_node (
	input  logic                           clk,
	input  logic                           rst,
	input  logic [coll_pkg::NUM_LINKS-1:0] link_valid,
	input  coll_pkg::flit_t                link_flit [coll_pkg::NUM_LINKS],
	output logic [coll_pkg::NUM_LINKS-1:0] link_busy,
	output logic                           result_valid,
	output coll_pkg::result_t              result,
	output logic                           drop_valid
);

	import coll_pkg::*;

	logic [NUM_LINKS-1:0] req;
	logic [NUM_LINKS-1:0] gnt;
	flit_t                buf_flit [NUM_LINKS];
	logic                 sel_valid;
	link_idx_t            sel_link;
	flit_t                sel_flit;

	// x, y, z negative children in link order
	for (genvar l = 0; l < NUM_LINKS; l++) begin : g_link
		link_ingress link_i (
			.clk      (clk),
			.rst      (rst),
			.in_valid (link_valid[l]),
			.in_flit  (link_flit[l]),
			.gnt      (gnt[l]),
			.req      (req[l]),
			.busy     (link_busy[l]),
			.flit     (buf_flit[l])
		);
	end

	table_arbiter arb_i (
		.clk       (clk),
		.rst       (rst),
		.req       (req),
		.flit      (buf_flit),
		.gnt       (gnt),
		.sel_valid (sel_valid),
		.sel_link  (sel_link),
		.sel_flit  (sel_flit)
	);

	context_store store_i (
		.clk          (clk),
		.rst          (rst),
		.sel_valid    (sel_valid),
		.sel_link     (sel_link),
		.sel_flit     (sel_flit),
		.result_valid (result_valid),
		.result       (result),
		.drop_valid   (drop_valid)
	);

endmodule

// File: bench/coll_node_sva.sv
`timescale 1ns/1ps

module coll_node_sva (
	input logic                           clk,
	input logic                           rst,
	input logic [coll_pkg::NUM_LINKS-1:0] link_valid,
	input logic [coll_pkg::NUM_LINKS-1:0] link_busy,
	input logic [coll_pkg::NUM_LINKS-1:0] req,
	input logic [coll_pkg::NUM_LINKS-1:0] gnt,
	input logic                           result_valid,
	input logic                           drop_valid
);

	import coll_pkg::*;

	// Cycles each pending request has gone without a grant
	int wait_cycles [NUM_LINKS];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int l = 0; l < NUM_LINKS; l++) begin
				wait_cycles[l] <= 0;
			end
		end else begin
			for (int l = 0; l < NUM_LINKS; l++) begin
				if (req[l] && !gnt[l]) begin
					wait_cycles[l] <= wait_cycles[l] + 1;
				end else begin
					wait_cycles[l] <= 0;
				end
			end
		end
	end

	a_gnt_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(gnt))
		else $error("gnt %b is not one-hot", gnt);

	a_gnt_has_req: assert property (@(posedge clk) disable iff (rst) (gnt & ~req) == '0)
		else $error("gnt %b given without req %b", gnt, req);

	// Round robin bounds the wait to one turn of the other links
	for (genvar l = 0; l < NUM_LINKS; l++) begin : g_wait
		a_req_granted: assert property (@(posedge clk) disable iff (rst)
			wait_cycles[l] < NUM_LINKS)
			else $error("link %0d waited %0d cycles for a grant", l, wait_cycles[l]);
	end

	a_no_strobe_busy: assert property (@(posedge clk) disable iff (rst)
		(link_valid & link_busy) == '0)
		else $error("strobe %b on busy links %b", link_valid, link_busy);

	a_result_or_drop: assert property (@(posedge clk) disable iff (rst)
		!(result_valid && drop_valid))
		else $error("result_valid and drop_valid high together");

endmodule

bind coll_node coll_node_sva sva_i (
	.clk          (clk),
	.rst          (rst),
	.link_valid   (link_valid),
	.link_busy    (link_busy),
	.req          (req),
	.gnt          (gnt),
	.result_valid (result_valid),
	.drop_valid   (drop_valid)
);

// File: bench/coll_node_tb.sv
`timescale 1ns/1ps

module coll_node_tb;

	import coll_pkg::*;

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 16;
	localparam int SEED         = 76658;
	localparam int DRAIN_LIMIT  = 40;
	// Flits sent by tests 1 to 6
	localparam int FLIT_BUDGET  = 4 + 3 + 12 + 5 + 6 + 4;
	localparam int WATCHDOG_NS  = (2 * RESET_CYCLES + 8 * FLIT_BUDGET) * CLK_PERIOD;

	// Reference view of one context
	typedef struct packed {
		logic                             cfg;
		op_e                              op;
		logic [NUM_LINKS-1:0]             mask;
		logic [RANK_W-1:0]                root;
		logic [RANK_W-1:0]                lrank;
		logic [NUM_LINKS-1:0]             rcvd;
		logic [1:0]                       cnt;
		logic [NUM_LINKS-1:0][DATA_W-1:0] vals;
	} ref_ctx_t;

	logic                 clk = 1'b0;
	logic                 rst;
	logic [NUM_LINKS-1:0] link_valid;
	flit_t                link_flit [NUM_LINKS];
	logic [NUM_LINKS-1:0] link_busy;
	logic                 result_valid;
	result_t              result;
	logic                 drop_valid;

	ref_ctx_t model [NUM_CTX];
	flit_t    stage [NUM_LINKS];
	result_t  exp_q [$];
	int       exp_drops = 0;
	int       errors = 0;
	int       test_errors = 0;
	int       tests_run = 0;
	int       tests_failed = 0;

	coll_node dut_i (
		.clk          (clk),
		.rst          (rst),
		.link_valid   (link_valid),
		.link_flit    (link_flit),
		.link_busy    (link_busy),
		.result_valid (result_valid),
		.result       (result),
		.drop_valid   (drop_valid)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [DATA_W-1:0] reduce_ref(input op_e op,
		input logic [NUM_LINKS-1:0][DATA_W-1:0] vals, input int n);
		logic [DATA_W-1:0] acc;
		acc = vals[0];
		for (int i = 1; i < n; i++) begin
			if (op == OP_SUM) begin
				acc = acc + vals[i];
			end else if (vals[i] > acc) begin
				acc = vals[i];
			end
		end
		return acc;
	endfunction

	// Predicts the outcome of one flit from link l
	task automatic model_apply(input int l, input flit_t f);
		ref_ctx_t e;
		result_t  r;
		e = model[f.ctx];
		if (f.kind == KIND_CFG) begin
			e = '0;
			e.cfg = 1'b1;
			e.op = f.body.cfg.op;
			e.mask = f.body.cfg.child_mask;
			e.root = f.body.cfg.root_rank;
			e.lrank = f.body.cfg.local_rank;
		end else if (!e.cfg || !e.mask[l] || e.rcvd[l]) begin
			exp_drops++;
		end else begin
			e.vals[e.cnt] = f.body.data.value;
			e.cnt++;
			e.rcvd[l] = 1'b1;
			if (e.rcvd == e.mask) begin
				r.ctx = f.ctx;
				r.root_rank = e.root;
				r.src_rank = e.lrank;
				r.value = reduce_ref(e.op, e.vals, int'(e.cnt));
				exp_q.push_back(r);
				e.rcvd = '0;
				e.cnt = '0;
			end
		end
		model[f.ctx] = e;
	endtask

	function automatic flit_t cfg_flit(input logic [CTX_W-1:0] ctx, input op_e op,
		input logic [NUM_LINKS-1:0] mask, input logic [RANK_W-1:0] root,
		input logic [RANK_W-1:0] lrank);
		flit_t f;
		f = '0;
		f.kind = KIND_CFG;
		f.ctx = ctx;
		f.src_rank = root;
		f.body.cfg.op = op;
		f.body.cfg.child_mask = mask;
		f.body.cfg.root_rank = root;
		f.body.cfg.local_rank = lrank;
		return f;
	endfunction

	function automatic flit_t data_flit(input logic [CTX_W-1:0] ctx,
		input logic [RANK_W-1:0] src, input logic [DATA_W-1:0] value);
		flit_t f;
		f = '0;
		f.kind = KIND_DATA;
		f.ctx = ctx;
		f.src_rank = src;
		f.body.data.value = value;
		return f;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	// Strobes the staged flits on every link in mask at once
	task automatic send_staged(input logic [NUM_LINKS-1:0] mask);
		do begin
			@(negedge clk);
		end while ((link_busy & mask) != '0);
		@(posedge clk);
		for (int l = 0; l < NUM_LINKS; l++) begin
			if (mask[l]) begin
				link_valid[l] <= 1'b1;
				link_flit[l] <= stage[l];
				model_apply(l, stage[l]);
			end
		end
		@(posedge clk);
		link_valid <= '0;
	endtask

	task automatic send_one(input int l, input flit_t f);
		stage[l] = f;
		send_staged(NUM_LINKS'(1 << l));
	endtask

	task automatic apply_reset();
		@(posedge clk);
		rst <= 1'b1;
		link_valid <= '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		for (int c = 0; c < NUM_CTX; c++) begin
			model[c] = '0;
		end
	endtask

	// Waits until every predicted pulse has been seen
	task automatic wait_idle();
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while ((exp_q.size() != 0 || exp_drops != 0 || link_busy != '0) &&
			n < DRAIN_LIMIT);
		assert (exp_q.size() == 0 && exp_drops == 0) else begin
			$display("timed out with %0d results and %0d drops still missing",
				exp_q.size(), exp_drops);
			errors++;
			exp_q.delete();
			exp_drops = 0;
		end
		repeat (3) @(negedge clk);
	endtask

	task automatic start_test();
		test_errors = errors;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors == test_errors) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed with %0d errors", tests_run, name,
				errors - test_errors);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Comparison
	////////////////////////////////////////////////////////////////////////////

	// Results may leave in any context order under contention
	always @(negedge clk) begin
		int idx;
		idx = -1;
		if (result_valid) begin
			foreach (exp_q[i]) begin
				if (idx < 0 && exp_q[i].ctx == result.ctx) begin
					idx = i;
				end
			end
			assert (idx >= 0) else begin
				$display("unexpected result for context %0d", result.ctx);
				errors++;
			end
			if (idx >= 0) begin
				// Fields in ctx/root/src/value order
				assert (result == exp_q[idx]) else begin
					$display("error: result %h/%h/%h/%h expected %h/%h/%h/%h",
						result.ctx, result.root_rank, result.src_rank, result.value,
						exp_q[idx].ctx, exp_q[idx].root_rank, exp_q[idx].src_rank,
						exp_q[idx].value);
					errors++;
				end
				exp_q.delete(idx);
			end
		end
		if (drop_valid) begin
			assert (exp_drops > 0) else begin
				$display("unexpected drop pulse");
				errors++;
			end
			if (exp_drops > 0) begin
				exp_drops--;
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, run did not finish", WATCHDOG_NS);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		void'($urandom(SEED));
		rst = 1'b1;
		link_valid = '0;
		for (int l = 0; l < NUM_LINKS; l++) begin
			link_flit[l] = '0;
			stage[l] = '0;
		end
		apply_reset();

		start_test();
		send_one(0, cfg_flit(2'd0, OP_SUM, 3'b111, 9'h000, 9'h041));
		send_one(0, data_flit(2'd0, 9'h101, 32'hffff_fff0));
		send_one(1, data_flit(2'd0, 9'h102, 32'h0000_0025));
		send_one(2, data_flit(2'd0, 9'h103, 32'h8000_0000));
		wait_idle();
		finish_test("sum over three children");

		start_test();
		send_one(2, cfg_flit(2'd1, OP_MAX, 3'b101, 9'h004, 9'h005));
		send_one(0, data_flit(2'd1, 9'h101, 32'h0000_7fff));
		// Link 2 still owes its value, nothing may come out yet
		repeat (5) @(negedge clk);
		send_one(2, data_flit(2'd1, 9'h103, 32'hf000_0001));
		wait_idle();
		finish_test("max over two children");

		start_test();
		for (int c = 0; c < 3; c++) begin
			send_one(c, cfg_flit(CTX_W'(c), c == 1 ? OP_MAX : OP_SUM, 3'b111,
				RANK_W'(16 * c), RANK_W'(16 * c + 1)));
		end
		for (int c = 0; c < 3; c++) begin
			for (int l = 0; l < NUM_LINKS; l++) begin
				stage[l] = data_flit(CTX_W'(c), RANK_W'(l + 1), $urandom());
			end
			send_staged('1);
		end
		wait_idle();
		finish_test("contended links over three contexts");

		start_test();
		send_one(1, data_flit(2'd3, 9'h102, 32'h1234_5678));
		send_one(0, data_flit(2'd0, 9'h101, 32'h0000_0100));
		send_one(0, data_flit(2'd0, 9'h101, 32'h0000_0200));
		send_one(1, data_flit(2'd0, 9'h102, 32'h0000_0010));
		send_one(2, data_flit(2'd0, 9'h103, 32'h0000_0001));
		wait_idle();
		finish_test("unconfigured and repeated data");

		start_test();
		// Stale values are larger, so a leftover would win the max
		send_one(0, data_flit(2'd2, 9'h101, 32'hffff_0000));
		send_one(1, data_flit(2'd2, 9'h102, 32'hfffe_0000));
		send_one(2, cfg_flit(2'd2, OP_MAX, 3'b111, 9'h010, 9'h011));
		stage[0] = data_flit(2'd2, 9'h101, 32'h0000_0033);
		stage[1] = data_flit(2'd2, 9'h102, 32'h0000_0077);
		stage[2] = data_flit(2'd2, 9'h103, 32'h0000_0055);
		send_staged('1);
		wait_idle();
		finish_test("reconfigure mid reduction");

		start_test();
		send_one(1, cfg_flit(2'd3, OP_SUM, 3'b011, 9'h020, 9'h021));
		wait_idle();
		// Reset lands while link 2 still holds a flit
		@(posedge clk);
		link_valid[2] <= 1'b1;
		link_flit[2] <= data_flit(2'd3, 9'h103, 32'h0000_0004);
		apply_reset();
		@(negedge clk);
		assert (link_busy == '0 && dut_i.gnt == '0) else begin
			$display("error: after reset link_busy = %h gnt = %h",
				link_busy, dut_i.gnt);
			errors++;
		end
		assert (!result_valid && !drop_valid) else begin
			$display("error: after reset result_valid = %h drop_valid = %h",
				result_valid, drop_valid);
			errors++;
		end
		send_one(0, data_flit(2'd3, 9'h101, 32'h0000_0001));
		send_one(1, data_flit(2'd0, 9'h102, 32'h0000_0002));
		wait_idle();
		finish_test("reset clears contexts");

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: sources.f
hdl/coll_pkg.sv
hdl/link_ingress.sv
hdl/table_arbiter.sv
hdl/context_store.sv
hdl/coll_node.sv
bench/coll_node_sva.sv
bench/coll_node_tb.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module coll_node_tb \
		-f sources.f -o coll_node_tb

run: compile
	./obj_dir/coll_node_tb | tee sim.log
	grep -q "^PASS: all tests$$" sim.log

clean:
	rm -rf obj_dir sim.log
